// ==== Makefile ====
# Verilator flow for the load ordering unit

VERILATOR ?= verilator
TOP       ?= loadOrderTb
FILELIST  ?= loadOrder.f
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= Vsim

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)

sim: $(OBJ_DIR)/$(SIM_BIN)
	-./$(OBJ_DIR)/$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/loadOrderAssert.sv ====
`timescale 1ns/1ps

module loadOrderAssert (
    input  logic clk,
    input  logic rst,
    input  logic dispatchReady,
    input  logic [loadOrderPkg::SQN_W-1:0] dispatchLoadSqN,
    input  logic [loadOrderPkg::SQN_W-1:0] maxLoadSqN,
    input  loadOrderPkg::BranchProv branchOut
);
    import loadOrderPkg::*;

    logic [SQN_W-1:0] gap;
    logic pastWindow;
    logic rewind;

    assign gap = dispatchLoadSqN - maxLoadSqN; // positive means past the window
    assign pastWindow = gap != '0 && !gap[SQN_W-1];
    assign rewind = branchOut.taken && branchOut.flush;

    branchPulse: assert property (@(posedge clk) disable iff (rst)
        branchOut.taken |=> !(branchOut.taken && branchOut.sqN == $past(branchOut.sqN)))
        else $error("branchOut stayed taken two cycles for one sqN");

    // counter frozen while the window is full
    loadWithinLimit: assert property (@(posedge clk) disable iff (rst)
        (pastWindow && !rewind) |=> dispatchLoadSqN == $past(dispatchLoadSqN))
        else $error("load accepted beyond maxLoadSqN");

    quietAfterReset: assert property (@(posedge clk)
        rst |=> (!branchOut.taken && dispatchReady
            && maxLoadSqN == SQN_W'(LB_ENTRIES - 1) && dispatchLoadSqN == '0))
        else $error("outputs not idle after reset");

endmodule

bind loadOrderUnit loadOrderAssert u_loadOrderAssert (
    .clk             (clk),
    .rst             (rst),
    .dispatchReady   (dispatchReady),
    .dispatchLoadSqN (dispatchLoadSqN),
    .maxLoadSqN      (maxLoadSqN),
    .branchOut       (branchOut)
);

// ==== dv/loadOrderTb.sv ====
`timescale 1ns/1ps

module loadOrderTb;
    import loadOrderPkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS = 6;
    localparam int TEST_CYCLES = 150; // upper bound on any single test
    localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * CLK_PERIOD + 400;

    typedef struct packed {
        LbEntry e;
        logic [SQN_W-1:0] lsqn;
    } ModelLoad;

    logic clk = 1'b0;
    logic rst;
    DispatchReq dispatch;
    logic dispatchReady;
    logic [SQN_W-1:0] dispatchLoadSqN;
    AguUop aguUop;
    logic [SQN_W-1:0] commitSqN;
    BranchProv extBranch;
    BranchProv branchOut;

    ModelLoad q[$]; // executed loads, oldest first
    logic [SQN_W-1:0] cnt;
    logic [SQN_W-1:0] base;
    logic [ADDR_W-1:0] loadAddr [LB_ENTRIES];
    BranchProv expVio;
    int checks;
    int errors;
    int testStartErrors;

    loadOrderUnit u_loadOrderUnit (
        .clk             (clk),
        .rst             (rst),
        .dispatch        (dispatch),
        .dispatchReady   (dispatchReady),
        .dispatchLoadSqN (dispatchLoadSqN),
        .aguUop          (aguUop),
        .commitSqN       (commitSqN),
        .extBranch       (extBranch),
        .branchOut       (branchOut)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic olderThan(input logic [SQN_W-1:0] a, input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] d;
        d = b - a;
        return d != '0 && !d[SQN_W-1];
    endfunction

    // four words, random byte offset
    function automatic logic [ADDR_W-1:0] poolAddr();
        return 32'h1000 + (($urandom % 4) << 2) + ($urandom % 4);
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // model step for the coming edge, then advance to the next falling edge
    task automatic tick();
        logic brT;
        logic expReady;
        logic accept;
        logic retire;
        logic live;
        logic [SQN_W-1:0] limit;
        ModelLoad m;
        #1;
        limit = base + SQN_W'(LB_ENTRIES - 1);
        expReady = !(dispatch.isLoad && olderThan(limit, cnt));
        check("dispatchReady", 64'(dispatchReady), 64'(expReady));
        check("dispatchLoadSqN", 64'(dispatchLoadSqN), 64'(cnt));
        brT = branchOut.taken;
        accept = dispatch.valid && dispatch.isLoad && expReady;
        retire = !brT && q.size() > 0 && q[0].lsqn == base && olderThan(q[0].e.sqN, commitSqN);
        live = aguUop.valid && !(brT && olderThan(branchOut.sqN, aguUop.sqN));
        if (brT) begin
            for (int i = q.size() - 1; i >= 0; i--) begin
                if (olderThan(branchOut.sqN, q[i].e.sqN)) q.delete(i);
            end
        end else if (retire) begin
            void'(q.pop_front());
        end
        if (brT && branchOut.flush) begin
            base = branchOut.loadSqN;
            cnt = branchOut.loadSqN;
        end else begin
            if (retire) base = base + 1'b1;
            if (accept) cnt = cnt + 1'b1;
        end
        if (live && aguUop.isLoad) begin
            m.e.valid = 1'b1;
            m.e.sqN = aguUop.sqN;
            m.e.addr = aguUop.addr[ADDR_W-1:2];
            m.lsqn = aguUop.loadSqN;
            q.push_back(m);
        end
        @(posedge clk);
        @(negedge clk);
        aguUop.valid = 1'b0;
        dispatch.valid = 1'b0;
        extBranch.taken = 1'b0;
    endtask

    task automatic resetDut();
        rst = 1'b1;
        dispatch = '0;
        aguUop = '0;
        commitSqN = '0;
        extBranch = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        q.delete();
        cnt = '0;
        base = '0;
    endtask

    // dispatch and execute n loads, sqN spaced by two
    task automatic fillLoads(input int n, input int firstSq);
        for (int k = 0; k < n; k++) begin
            dispatch = '{valid: 1'b1, isLoad: 1'b1, sqN: SQN_W'(firstSq + 2 * k)};
            aguUop = '0;
            aguUop.valid = 1'b1;
            aguUop.isLoad = 1'b1;
            aguUop.addr = poolAddr();
            aguUop.pc = $urandom;
            aguUop.sqN = SQN_W'(firstSq + 2 * k);
            aguUop.loadSqN = cnt;
            loadAddr[k] = aguUop.addr;
            tick();
        end
    endtask

    task automatic driveStore(input logic [SQN_W-1:0] sqN, input logic [ADDR_W-1:0] addr);
        aguUop = '0;
        aguUop.valid = 1'b1;
        aguUop.addr = addr;
        aguUop.pc = $urandom;
        aguUop.sqN = sqN;
        aguUop.loadSqN = cnt;
        aguUop.storeSqN = SQN_W'($urandom);
        aguUop.fetchID = FETCH_ID_W'($urandom);
        expVio = '0;
        foreach (q[i]) begin
            if (q[i].e.addr == addr[ADDR_W-1:2] && !olderThan(q[i].e.sqN, sqN)) expVio.taken = 1'b1;
        end
        expVio.dstPC = aguUop.pc;
        expVio.sqN = sqN;
        expVio.loadSqN = aguUop.loadSqN;
        expVio.storeSqN = aguUop.storeSqN;
        expVio.fetchID = aguUop.fetchID;
    endtask

    task automatic compareBranch(input BranchProv exp);
        check("branchOut.taken", 64'(branchOut.taken), 64'(exp.taken));
        if (exp.taken) begin
            check("branchOut.flush", 64'(branchOut.flush), 64'(exp.flush));
            check("branchOut.dstPC", 64'(branchOut.dstPC), 64'(exp.dstPC));
            check("branchOut.sqN", 64'(branchOut.sqN), 64'(exp.sqN));
            check("branchOut.loadSqN", 64'(branchOut.loadSqN), 64'(exp.loadSqN));
            check("branchOut.storeSqN", 64'(branchOut.storeSqN), 64'(exp.storeSqN));
            check("branchOut.fetchID", 64'(branchOut.fetchID), 64'(exp.fetchID));
        end
    endtask

    task automatic storeCheck(input logic [SQN_W-1:0] sqN, input logic [ADDR_W-1:0] addr);
        driveStore(sqN, addr);
        tick();
        tick(); // buffer stage, selector stage
        compareBranch(expVio);
        tick();
    endtask

    task automatic reportTest(input string name);
        $display("%-18s done, %0d mismatches", name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    task automatic testAllocation();
        int loads;
        int sq;
        logic isStore;
        loads = 0;
        sq = 0;
        resetDut();
        while (loads < LB_ENTRIES) begin
            isStore = ($urandom % 3) == 0;
            dispatch = '{valid: 1'b1, isLoad: !isStore, sqN: SQN_W'(sq)};
            tick();
            sq++;
            if (!isStore) loads++;
        end
        dispatch = '{valid: 1'b1, isLoad: 1'b1, sqN: SQN_W'(sq)};
        tick(); // window full, load refused
        dispatch = '{valid: 1'b1, isLoad: 1'b0, sqN: SQN_W'(sq)};
        tick();
        reportTest("allocation");
    endtask

    task automatic testNoFalseViolation();
        resetDut();
        fillLoads(6, 10);
        for (int i = 0; i < 4; i++) storeCheck(SQN_W'(22 + 2 * i), poolAddr());
        for (int i = 0; i < 2; i++) storeCheck(SQN_W'(9 - i), 32'h8000 + ($urandom % 64));
        reportTest("noFalseViolation");
    endtask

    task automatic testViolation();
        resetDut();
        fillLoads(8, 10);
        for (int i = 0; i < 6; i++) storeCheck(SQN_W'(9 + 2 * ($urandom % 8)), poolAddr());
        reportTest("violation");
    endtask

    task automatic testCommit();
        resetDut();
        fillLoads(LB_ENTRIES, 0);
        dispatch.isLoad = 1'b1; // probe only, valid stays low
        tick();
        for (int r = 0; r < 4; r++) begin
            commitSqN = commitSqN + SQN_W'(2 + $urandom % 6);
            repeat (4) tick();
        end
        commitSqN = SQN_W'(31);
        repeat (LB_ENTRIES + 1) tick();
        dispatch = '{valid: 1'b1, isLoad: 1'b1, sqN: SQN_W'(33)};
        tick();
        check("dispatchLoadSqN", 64'(dispatchLoadSqN), 64'(LB_ENTRIES + 1));
        reportTest("commit");
    endtask

    task automatic testFlush();
        BranchProv br;
        resetDut();
        fillLoads(6, 10);
        br = '{taken: 1'b1, flush: 1'b1, dstPC: $urandom, sqN: SQN_W'($urandom % 10),
            loadSqN: '0, storeSqN: SQN_W'($urandom), fetchID: FETCH_ID_W'($urandom)};
        extBranch = br;
        tick();
        compareBranch(br);
        tick();
        check("dispatchLoadSqN", 64'(dispatchLoadSqN), 64'(br.loadSqN));
        for (int k = 0; k < 3; k++) storeCheck(br.sqN + 1'b1, loadAddr[$urandom % 6]);
        dispatch = '{valid: 1'b1, isLoad: 1'b1, sqN: br.sqN + SQN_W'(2)};
        tick();
        reportTest("flush");
    endtask

    task automatic testArbitration();
        BranchProv ext;
        for (int r = 0; r < 4; r++) begin
            resetDut();
            fillLoads(4, 20);
            driveStore(SQN_W'(19), loadAddr[1]); // older than load at sqN 22
            tick();
            ext = '{taken: 1'b1, flush: 1'b0, dstPC: $urandom, sqN: SQN_W'(10 + $urandom % 19),
                loadSqN: SQN_W'($urandom), storeSqN: SQN_W'($urandom),
                fetchID: FETCH_ID_W'($urandom)};
            if (ext.sqN == SQN_W'(19)) ext.sqN = SQN_W'(18);
            extBranch = ext;
            tick();
            compareBranch(olderThan(ext.sqN, SQN_W'(19)) ? ext : expVio);
            tick();
        end
        reportTest("arbitration");
    endtask

    initial begin
        void'($urandom(32'hf596_e8b6));
        checks = 0;
        errors = 0;
        testStartErrors = 0;
        testAllocation();
        testNoFalseViolation();
        testViolation();
        testCommit();
        testFlush();
        testArbitration();
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== loadOrder.f ====
logic/loadOrderPkg.sv
logic/loadSqnAllocator.sv
logic/loadBuffer.sv
logic/branchSelector.sv
logic/loadOrderUnit.sv
dv/loadOrderAssert.sv
dv/loadOrderTb.sv

// ==== logic/branchSelector.sv ====
`timescale 1ns/1ps

module branchSelector (
    input  logic clk,
    input  logic rst,

    input  loadOrderPkg::BranchProv extBranch,
    input  loadOrderPkg::BranchProv violation,

    output loadOrderPkg::BranchProv branchOut
);
    import loadOrderPkg::*;

    logic extLive;
    logic vioLive;
    BranchProv pick;

    // a candidate not older than the redirect in flight is squashed by it
    always_comb begin
        extLive = extBranch.taken;
        vioLive = violation.taken;
        if (branchOut.taken) begin
            if (!isOlder(extBranch.sqN, branchOut.sqN)) begin
                extLive = 1'b0;
            end
            if (!isOlder(violation.sqN, branchOut.sqN)) begin
                vioLive = 1'b0;
            end
        end
    end

    // older sqN wins, ties go to the ALU side
    always_comb begin
        if (extLive && vioLive) begin
            pick = isOlder(violation.sqN, extBranch.sqN) ? violation : extBranch;
        end else if (vioLive) begin
            pick = violation;
        end else begin
            pick = extBranch;
        end
        pick.taken = extLive || vioLive;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branchOut.taken <= 1'b0;
        end else begin
            branchOut <= pick; // one cycle pulse
        end
    end

endmodule

// ==== logic/loadBuffer.sv ====
`timescale 1ns/1ps

module loadBuffer (
    input  logic clk,
    input  logic rst,

    input  logic [loadOrderPkg::SQN_W-1:0] commitSqN,
    input  loadOrderPkg::AguUop uop,
    input  loadOrderPkg::BranchProv branch,

    output loadOrderPkg::BranchProv violation,
    output logic [loadOrderPkg::SQN_W-1:0] maxLoadSqN
);
    import loadOrderPkg::*;

    LbEntry entries [LB_ENTRIES];

    logic [SQN_W-1:0] baseIndex; // load number held in entries[0]
    logic [SQN_W-1:0] baseNext;
    logic [LB_IDX_W-1:0] loadIdx;
    logic uopLive;
    logic headRetire;
    logic storeHit;
    BranchProv violationNext;

    // uops behind a taken redirect are already squashed
    assign uopLive = uop.valid && !(branch.taken && isOlder(branch.sqN, uop.sqN));

    // head leaves once its instruction is committed
    assign headRetire = !branch.taken && entries[0].valid
        && isOlder(entries[0].sqN, commitSqN);

    always_comb begin
        baseNext = baseIndex;
        if (branch.taken && branch.flush) begin
            baseNext = branch.loadSqN;
        end else if (headRetire) begin
            baseNext = baseIndex + 1'b1;
        end
    end

    // slot relative to the base after this cycle's shift
    assign loadIdx = uop.loadSqN[LB_IDX_W-1:0] - baseNext[LB_IDX_W-1:0];

    // any executed load at the same word that is not older than the store
    always_comb begin
        storeHit = 1'b0;
        for (int j = 0; j < LB_ENTRIES; j++) begin
            if (entries[j].valid && entries[j].addr == uop.addr[ADDR_W-1:2]
                    && !isOlder(entries[j].sqN, uop.sqN)) begin
                storeHit = 1'b1;
            end
        end
    end

    always_comb begin
        violationNext.taken = uopLive && !uop.isLoad && storeHit;
        violationNext.flush = 1'b0; // replay only
        violationNext.dstPC = uop.pc;
        violationNext.sqN = uop.sqN;
        violationNext.loadSqN = uop.loadSqN;
        violationNext.storeSqN = uop.storeSqN;
        violationNext.fetchID = uop.fetchID;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
            baseIndex <= '0;
            maxLoadSqN <= SQN_W'(LB_ENTRIES - 1);
            violation.taken <= 1'b0;
        end else begin
            if (branch.taken) begin
                for (int i = 0; i < LB_ENTRIES; i++) begin
                    if (isOlder(branch.sqN, entries[i].sqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end else if (headRetire) begin
                for (int i = 0; i < LB_ENTRIES - 1; i++) begin
                    entries[i] <= entries[i + 1];
                end
                entries[LB_ENTRIES - 1].valid <= 1'b0;
            end

            // overrides the shift or squash for its own slot
            if (uopLive && uop.isLoad) begin
                entries[loadIdx] <= '{
                    valid: 1'b1,
                    sqN: uop.sqN,
                    addr: uop.addr[ADDR_W-1:2]
                };
            end

            baseIndex <= baseNext;
            maxLoadSqN <= baseNext + SQN_W'(LB_ENTRIES - 1);
            violation <= violationNext; // valid for this one cycle only
        end
    end

endmodule

// ==== logic/loadOrderPkg.sv ====
package loadOrderPkg;

    localparam int SQN_W = 6;
    localparam int ADDR_W = 32;
    localparam int PC_W = 32;
    localparam int FETCH_ID_W = 5;
    localparam int LB_ENTRIES = 16;
    localparam int LB_IDX_W = 4;

    typedef struct packed {
        logic valid;
        logic isLoad;
        logic [ADDR_W-1:0] addr;
        logic [PC_W-1:0] pc;
        logic [SQN_W-1:0] sqN;
        logic [SQN_W-1:0] loadSqN;
        logic [SQN_W-1:0] storeSqN;
        logic [FETCH_ID_W-1:0] fetchID;
    } AguUop;

    typedef struct packed {
        logic taken;
        logic flush;
        logic [PC_W-1:0] dstPC;
        logic [SQN_W-1:0] sqN;
        logic [SQN_W-1:0] loadSqN;
        logic [SQN_W-1:0] storeSqN;
        logic [FETCH_ID_W-1:0] fetchID;
    } BranchProv;

    typedef struct packed {
        logic valid;
        logic [SQN_W-1:0] sqN;
        logic [ADDR_W-3:0] addr; // word address
    } LbEntry;

    typedef struct packed {
        logic valid;
        logic isLoad;
        logic [SQN_W-1:0] sqN;
    } DispatchReq;

    // true when a is older than b in wrapped sequence order
    function automatic logic isOlder(input logic [SQN_W-1:0] a, input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] diff;
        diff = b - a;
        return $signed(diff) > 0;
    endfunction

endpackage

// ==== logic/loadOrderUnit.sv ====
`timescale 1ns/1ps

module loadOrderUnit (
    input  logic clk,
    input  logic rst,

    // dispatch
    input  loadOrderPkg::DispatchReq dispatch,
    output logic dispatchReady,
    output logic [loadOrderPkg::SQN_W-1:0] dispatchLoadSqN,

    // address generation
    input  loadOrderPkg::AguUop aguUop,

    input  logic [loadOrderPkg::SQN_W-1:0] commitSqN,
    input  loadOrderPkg::BranchProv extBranch,

    output loadOrderPkg::BranchProv branchOut
);
    import loadOrderPkg::*;

    logic [SQN_W-1:0] maxLoadSqN;
    BranchProv violation;

    loadSqnAllocator u_loadSqnAllocator (
        .clk             (clk),
        .rst             (rst),
        .dispatch        (dispatch),
        .maxLoadSqN      (maxLoadSqN),
        .branch          (branchOut),
        .dispatchReady   (dispatchReady),
        .dispatchLoadSqN (dispatchLoadSqN)
    );

    loadBuffer u_loadBuffer (
        .clk        (clk),
        .rst        (rst),
        .commitSqN  (commitSqN),
        .uop        (aguUop),
        .branch     (branchOut),
        .violation  (violation),
        .maxLoadSqN (maxLoadSqN)
    );

    // merged redirect feeds back into buffer and allocator
    branchSelector u_branchSelector (
        .clk       (clk),
        .rst       (rst),
        .extBranch (extBranch),
        .violation (violation),
        .branchOut (branchOut)
    );

endmodule

// ==== logic/loadSqnAllocator.sv ====
`timescale 1ns/1ps

module loadSqnAllocator (
    input  logic clk,
    input  logic rst,

    input  loadOrderPkg::DispatchReq dispatch,
    input  logic [loadOrderPkg::SQN_W-1:0] maxLoadSqN,
    input  loadOrderPkg::BranchProv branch,

    output logic dispatchReady,
    output logic [loadOrderPkg::SQN_W-1:0] dispatchLoadSqN
);
    import loadOrderPkg::*;

    logic [SQN_W-1:0] loadSqN;
    logic overLimit;
    logic loadAccept;
    logic rewind;

    // counter already past the last slot the buffer can take
    assign overLimit = isOlder(maxLoadSqN, loadSqN);

    // stores never need a load slot
    assign dispatchReady = !(dispatch.isLoad && overLimit);

    assign loadAccept = dispatch.valid && dispatch.isLoad && dispatchReady;

    assign rewind = branch.taken && branch.flush;

    assign dispatchLoadSqN = loadSqN;

    always_ff @(posedge clk) begin
        if (rst) begin
            loadSqN <= '0;
        end else if (rewind) begin
            loadSqN <= branch.loadSqN; // squashed loads give their numbers back
        end else if (loadAccept) begin
            loadSqN <= loadSqN + 1'b1;
        end
    end

endmodule
